// ==== design/cache_pkg.sv ====
// cache package: shared bus widths, replacement LFSR constants and controller states
package cache_pkg;

    // cpu and memory port widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int STRB_W = WORD_W / 8;

    // replacement LFSR, 16-bit maximal length (taps 16,14,13,11)
    localparam int LFSR_W = 16;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hace1;

    // main controller states
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        LOOKUP     = 3'd1,
        MISS       = 3'd2, // clean victim, fetch line
        DIRTY_MISS = 3'd3, // wait for write-back slot
        REPLACE    = 3'd4, // write back victim, request refill
        REFILL     = 3'd5
    } cache_state_e;

endpackage

// ==== design/cache_tag_store.sv ====
// cache tag store: per-way tag, valid and dirty arrays with registered read and hit compare
`timescale 1ns/100ps

module cache_tag_store
    import cache_pkg::*;
#(
    parameter int NUM_WAY        = 2,
    parameter int NUM_LINE       = 256,
    parameter int BYTES_PER_LINE = 16
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [$clog2(NUM_LINE)-1:0]              read_index,
    input  logic [ADDR_W-$clog2(NUM_LINE)-$clog2(BYTES_PER_LINE)-1:0] lookup_tag,
    input  logic [NUM_WAY-1:0]                       victim_way,
    input  logic                                     tag_we,
    input  logic [NUM_WAY-1:0]                       tag_way,
    input  logic [ADDR_W-$clog2(NUM_LINE)-$clog2(BYTES_PER_LINE)-1:0] tag_wdata,
    input  logic                                     dirty_set,
    input  logic [NUM_WAY-1:0]                       dirty_way,
    input  logic [$clog2(NUM_LINE)-1:0]              write_index,
    output logic [NUM_WAY-1:0]                       hit_way,
    output logic [NUM_WAY-1:0]                       valid_ways,
    output logic [NUM_WAY-1:0]                       dirty_ways,
    output logic [ADDR_W-$clog2(NUM_LINE)-$clog2(BYTES_PER_LINE)-1:0] victim_tag
);

    localparam int INDEX_W = $clog2(NUM_LINE);
    localparam int TAG_W   = ADDR_W - INDEX_W - $clog2(BYTES_PER_LINE);

    logic [NUM_WAY-1:0][NUM_LINE-1:0] valid_bits;
    logic [NUM_WAY-1:0][NUM_LINE-1:0] dirty_bits;
    logic [TAG_W-1:0]                 way_tag [NUM_WAY];

    // a refill sets valid and starts clean, a write marks dirty afterwards
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            for (int w = 0; w < NUM_WAY; w++) begin
                if (tag_we && tag_way[w]) begin
                    valid_bits[w][write_index] <= 1'b1;
                    dirty_bits[w][write_index] <= 1'b0;
                end
                if (dirty_set && dirty_way[w])
                    dirty_bits[w][write_index] <= 1'b1;
            end
        end
    end

    for (genvar w = 0; w < NUM_WAY; w++) begin : g_way
        logic [TAG_W-1:0] tags [NUM_LINE];
        logic [TAG_W-1:0] tag_q;
        logic             valid_q;
        logic             dirty_q;

        always_ff @(posedge clk) begin
            if (tag_we && tag_way[w])
                tags[write_index] <= tag_wdata;
            tag_q   <= tags[read_index];
            valid_q <= valid_bits[w][read_index];
            dirty_q <= dirty_bits[w][read_index];
        end

        assign valid_ways[w] = valid_q;
        assign dirty_ways[w] = dirty_q;
        assign hit_way[w]    = valid_q && (tag_q == lookup_tag);
        assign way_tag[w]    = tag_q;
    end

    always_comb begin
        victim_tag = '0;
        for (int w = 0; w < NUM_WAY; w++)
            if (victim_way[w])
                victim_tag |= way_tag[w];
    end

    // a tag may live in one way only, relies on the controller refilling on miss only
    assert property (@(posedge clk) disable iff (reset) $onehot0(hit_way))
        else $error("tag store: multiple ways hit");

endmodule

// ==== design/cache_data_store.sv ====
// cache data store: per-way line storage with byte-strobed word writes and registered line read
`timescale 1ns/100ps

module cache_data_store
    import cache_pkg::*;
#(
    parameter int NUM_WAY        = 2,
    parameter int NUM_LINE       = 256,
    parameter int BYTES_PER_LINE = 16
) (
    input  logic                                         clk,
    input  logic [$clog2(NUM_LINE)-1:0]                  read_index,
    input  logic [$clog2(BYTES_PER_LINE/STRB_W)-1:0]     read_bank,
    input  logic [NUM_WAY-1:0]                           hit_way,
    input  logic [NUM_WAY-1:0]                           victim_way,
    input  logic                                         data_we,
    input  logic [NUM_WAY-1:0]                           data_way,
    input  logic [$clog2(NUM_LINE)-1:0]                  write_index,
    input  logic [$clog2(BYTES_PER_LINE/STRB_W)-1:0]     data_bank,
    input  logic [STRB_W-1:0]                            data_strb,
    input  logic [WORD_W-1:0]                            data_wdata,
    output logic [WORD_W-1:0]                            read_word,
    output logic [BYTES_PER_LINE*8-1:0]                  victim_line
);

    localparam int WORDS_PER_LINE = BYTES_PER_LINE / STRB_W;

    logic [WORDS_PER_LINE-1:0][WORD_W-1:0] way_line [NUM_WAY];

    for (genvar w = 0; w < NUM_WAY; w++) begin : g_way
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] lines [NUM_LINE];
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_q;

        always_ff @(posedge clk) begin
            if (data_we && data_way[w]) begin
                for (int b = 0; b < STRB_W; b++)
                    if (data_strb[b])
                        lines[write_index][data_bank][b*8 +: 8] <= data_wdata[b*8 +: 8];
            end
            line_q <= lines[read_index]; // whole line, one cycle latency
        end

        assign way_line[w] = line_q;
    end

    // one-hot selects, hit word for the cpu and the victim line for write-back
    always_comb begin
        read_word   = '0;
        victim_line = '0;
        for (int w = 0; w < NUM_WAY; w++) begin
            if (hit_way[w])
                read_word |= way_line[w][read_bank];
            if (victim_way[w])
                victim_line |= way_line[w];
        end
    end

endmodule

// ==== design/cache_victim_select.sv ====
// victim select: replacement way choice, first invalid way else pseudo-random from an LFSR
`timescale 1ns/100ps

module cache_victim_select
    import cache_pkg::*;
#(
    parameter int NUM_WAY = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               lookup_en,
    input  logic [NUM_WAY-1:0] valid_ways,
    output logic [NUM_WAY-1:0] replace_way
);

    logic [LFSR_W-1:0]  lfsr;
    logic               feedback;
    logic [NUM_WAY-1:0] invalid_ways;

    assign feedback     = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    assign invalid_ways = ~valid_ways;

    always_ff @(posedge clk) begin
        if (reset)
            lfsr <= LFSR_SEED;
        else if (lookup_en)
            lfsr <= {lfsr[LFSR_W-2:0], feedback}; // one step per lookup
    end

    always_comb begin
        if (|invalid_ways)
            replace_way = invalid_ways & (~invalid_ways + 1'b1); // lowest invalid
        else
            replace_way = NUM_WAY'(1) << (lfsr % NUM_WAY);
    end

    assert property (@(posedge clk) disable iff (reset) $onehot(replace_way))
        else $error("victim select: replace way not one-hot");

endmodule

// ==== design/cache_ctrl.sv ====
// cache controller: request FSM, hit service, write-back and line refill with write merge
`timescale 1ns/100ps

module cache_ctrl
    import cache_pkg::*;
#(
    parameter int NUM_WAY        = 2,
    parameter int NUM_LINE       = 256,
    parameter int BYTES_PER_LINE = 16
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    valid,
    input  logic                                    write,
    input  logic [ADDR_W-1:0]                       addr,
    input  logic [STRB_W-1:0]                       wstrb,
    input  logic [WORD_W-1:0]                       wdata,
    output logic                                    addr_ok,
    output logic                                    data_ok,
    output logic [WORD_W-1:0]                       rdata,
    input  logic [NUM_WAY-1:0]                      hit_way,
    input  logic [NUM_WAY-1:0]                      valid_ways,
    input  logic [NUM_WAY-1:0]                      dirty_ways,
    input  logic [ADDR_W-$clog2(NUM_LINE)-$clog2(BYTES_PER_LINE)-1:0] victim_tag,
    input  logic [WORD_W-1:0]                       read_word,
    input  logic [BYTES_PER_LINE*8-1:0]             victim_line,
    input  logic [NUM_WAY-1:0]                      replace_way,
    output logic [$clog2(NUM_LINE)-1:0]             read_index,
    output logic [$clog2(BYTES_PER_LINE/STRB_W)-1:0] read_bank,
    output logic [ADDR_W-$clog2(NUM_LINE)-$clog2(BYTES_PER_LINE)-1:0] lookup_tag,
    output logic                                    lookup_en,
    output logic [NUM_WAY-1:0]                      victim_way,
    output logic                                    tag_we,
    output logic [NUM_WAY-1:0]                      tag_way,
    output logic [ADDR_W-$clog2(NUM_LINE)-$clog2(BYTES_PER_LINE)-1:0] tag_wdata,
    output logic [$clog2(NUM_LINE)-1:0]             write_index,
    output logic                                    dirty_set,
    output logic [NUM_WAY-1:0]                      dirty_way,
    output logic                                    data_we,
    output logic [NUM_WAY-1:0]                      data_way,
    output logic [$clog2(BYTES_PER_LINE/STRB_W)-1:0] data_bank,
    output logic [STRB_W-1:0]                       data_strb,
    output logic [WORD_W-1:0]                       data_wdata,
    output logic                                    rd_req,
    input  logic                                    rd_rdy,
    output logic [ADDR_W-1:0]                       rd_addr,
    input  logic                                    ret_valid,
    input  logic                                    ret_last,
    input  logic [WORD_W-1:0]                       ret_data,
    output logic                                    wr_req,
    input  logic                                    wr_rdy,
    output logic [ADDR_W-1:0]                       wr_addr,
    output logic [BYTES_PER_LINE*8-1:0]             wr_data
);

    localparam int OFFSET_W = $clog2(BYTES_PER_LINE);
    localparam int INDEX_W  = $clog2(NUM_LINE);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int BANK_W   = $clog2(BYTES_PER_LINE / STRB_W);

    cache_state_e state;
    cache_state_e state_next;

    // request buffer
    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_index;
    logic [BANK_W-1:0]  req_bank;
    logic               req_write;
    logic [STRB_W-1:0]  req_wstrb;
    logic [WORD_W-1:0]  req_wdata;

    logic              hit;
    logic              victim_dirty;
    logic              first_replace;
    logic [BANK_W-1:0] refill_cnt;
    logic              refill_beat;
    logic              refill_req_word;
    logic [WORD_W-1:0] merged_word;
    logic              lookup_ok;
    logic              refill_ok;

    assign hit          = |hit_way;
    assign victim_dirty = |(replace_way & valid_ways & dirty_ways);
    assign addr_ok      = (state == IDLE) && valid;

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_tag   <= addr[ADDR_W-1 -: TAG_W];
            req_index <= addr[OFFSET_W +: INDEX_W];
            req_bank  <= addr[2 +: BANK_W];
            req_write <= write;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
        if (state == LOOKUP)
            victim_way <= replace_way;
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:       if (valid) state_next = LOOKUP;
            LOOKUP: begin
                if (hit)
                    state_next = IDLE;
                else if (victim_dirty)
                    state_next = DIRTY_MISS;
                else
                    state_next = MISS;
            end
            MISS:       if (rd_rdy) state_next = REFILL;
            DIRTY_MISS: if (wr_rdy) state_next = REPLACE;
            REPLACE:    if (rd_rdy) state_next = REFILL;
            REFILL:     if (ret_valid && ret_last) state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= IDLE;
            first_replace <= 1'b0;
        end else begin
            state         <= state_next;
            first_replace <= (state == DIRTY_MISS) && wr_rdy;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || state != REFILL)
            refill_cnt <= '0;
        else if (ret_valid)
            refill_cnt <= refill_cnt + 1'b1;
    end

    // store side lookups
    assign read_index = (state == IDLE) ? addr[OFFSET_W +: INDEX_W] : req_index;
    assign read_bank  = req_bank;
    assign lookup_tag = req_tag;
    assign lookup_en  = (state == LOOKUP);

    assign refill_beat     = (state == REFILL) && ret_valid;
    assign refill_req_word = (refill_cnt == req_bank);

    // pending write bytes land on the returning word
    always_comb begin
        for (int b = 0; b < STRB_W; b++)
            merged_word[b*8 +: 8] = req_wstrb[b] ? req_wdata[b*8 +: 8] : ret_data[b*8 +: 8];
    end

    always_comb begin
        data_we     = 1'b0;
        data_way    = victim_way;
        data_bank   = refill_cnt;
        data_strb   = '1;
        data_wdata  = (req_write && refill_req_word) ? merged_word : ret_data;
        dirty_set   = 1'b0;
        dirty_way   = victim_way;
        if (state == LOOKUP) begin
            data_we    = hit && req_write;
            data_way   = hit_way;
            data_bank  = req_bank;
            data_strb  = req_wstrb;
            data_wdata = req_wdata;
            dirty_set  = hit && req_write;
            dirty_way  = hit_way;
        end else if (refill_beat) begin
            data_we   = 1'b1;
            dirty_set = ret_last && req_write; // line arrives already modified
        end
    end

    assign tag_we      = refill_beat && ret_last;
    assign tag_way     = victim_way;
    assign tag_wdata   = req_tag;
    assign write_index = req_index;

    // cpu response
    assign lookup_ok = (state == LOOKUP) && (hit || req_write); // writes never stall
    assign refill_ok = refill_beat && refill_req_word && !req_write;
    assign data_ok   = lookup_ok || refill_ok;
    assign rdata     = lookup_ok ? read_word : ret_data;

    // memory side
    assign rd_req  = (state == MISS) || (state == REPLACE);
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};
    assign wr_req  = first_replace;
    assign wr_addr = {victim_tag, req_index, {OFFSET_W{1'b0}}};
    assign wr_data = victim_line;

    assert property (@(posedge clk) disable iff (reset) ret_valid |-> state == REFILL)
        else $error("cache ctrl: refill data outside REFILL");

    assert property (@(posedge clk) disable iff (reset) wr_req |=> !wr_req)
        else $error("cache ctrl: wr_req held longer than one cycle");

endmodule

// ==== design/cache_top.sv ====
// cache top: set-associative write-back data cache built from stores, victim select and FSM
`timescale 1ns/100ps

module cache_top
    import cache_pkg::*;
#(
    parameter int NUM_WAY        = 2,
    parameter int NUM_LINE       = 256,
    parameter int BYTES_PER_LINE = 16
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        valid,
    input  logic                        write,
    input  logic [ADDR_W-1:0]           addr,
    input  logic [STRB_W-1:0]           wstrb,
    input  logic [WORD_W-1:0]           wdata,
    output logic                        addr_ok,
    output logic                        data_ok,
    output logic [WORD_W-1:0]           rdata,
    output logic                        rd_req,
    output logic [ADDR_W-1:0]           rd_addr,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  logic                        ret_last,
    input  logic [WORD_W-1:0]           ret_data,
    output logic                        wr_req,
    output logic [ADDR_W-1:0]           wr_addr,
    output logic [BYTES_PER_LINE*8-1:0] wr_data,
    input  logic                        wr_rdy
);

    localparam int INDEX_W = $clog2(NUM_LINE);
    localparam int TAG_W   = ADDR_W - INDEX_W - $clog2(BYTES_PER_LINE);
    localparam int BANK_W  = $clog2(BYTES_PER_LINE / STRB_W);
    localparam int LINE_W  = BYTES_PER_LINE * 8;

    logic [INDEX_W-1:0] read_index;
    logic [INDEX_W-1:0] write_index;
    logic [BANK_W-1:0]  read_bank;
    logic [BANK_W-1:0]  data_bank;
    logic [TAG_W-1:0]   lookup_tag;
    logic [TAG_W-1:0]   tag_wdata;
    logic [TAG_W-1:0]   victim_tag;
    logic [NUM_WAY-1:0] hit_way;
    logic [NUM_WAY-1:0] valid_ways;
    logic [NUM_WAY-1:0] dirty_ways;
    logic [NUM_WAY-1:0] replace_way;
    logic [NUM_WAY-1:0] victim_way;
    logic [NUM_WAY-1:0] tag_way;
    logic [NUM_WAY-1:0] dirty_way;
    logic [NUM_WAY-1:0] data_way;
    logic               lookup_en;
    logic               tag_we;
    logic               dirty_set;
    logic               data_we;
    logic [STRB_W-1:0]  data_strb;
    logic [WORD_W-1:0]  data_wdata;
    logic [WORD_W-1:0]  read_word;
    logic [LINE_W-1:0]  victim_line;

    // port names match the nets above
    cache_tag_store #(
        .NUM_WAY(NUM_WAY), .NUM_LINE(NUM_LINE), .BYTES_PER_LINE(BYTES_PER_LINE)
    ) i_tag_store (.*);

    cache_data_store #(
        .NUM_WAY(NUM_WAY), .NUM_LINE(NUM_LINE), .BYTES_PER_LINE(BYTES_PER_LINE)
    ) i_data_store (.*);

    cache_victim_select #(.NUM_WAY(NUM_WAY)) i_victim_select (.*);

    cache_ctrl #(
        .NUM_WAY(NUM_WAY), .NUM_LINE(NUM_LINE), .BYTES_PER_LINE(BYTES_PER_LINE)
    ) i_ctrl (.*);

endmodule

// ==== verif/cache_mem_model.sv ====
// memory model: line-burst memory behind the cache with random handshake and beat delays
`timescale 1ns/100ps

module cache_mem_model
    import cache_pkg::*;
#(
    parameter int                BYTES_PER_LINE = 16,
    parameter logic [WORD_W-1:0] INIT_XOR       = '0
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        rd_req,
    input  logic [ADDR_W-1:0]           rd_addr,
    output logic                        rd_rdy,
    output logic                        ret_valid,
    output logic                        ret_last,
    output logic [WORD_W-1:0]           ret_data,
    input  logic                        wr_req,
    input  logic [ADDR_W-1:0]           wr_addr,
    input  logic [BYTES_PER_LINE*8-1:0] wr_data,
    output logic                        wr_rdy
);

    localparam int WORDS_PER_LINE = BYTES_PER_LINE / STRB_W;

    logic [WORD_W-1:0] mem [logic [ADDR_W-1:0]]; // written-back words only
    integer            seed = 2;
    logic              busy;
    logic [ADDR_W-1:0] line_addr;
    int                beat;

    function automatic logic [WORD_W-1:0] load_word(logic [ADDR_W-1:0] byte_addr);
        if (mem.exists(byte_addr))
            return mem[byte_addr];
        return byte_addr ^ INIT_XOR; // never written
    endfunction

    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        busy      = 1'b0;
        beat      = 0;
        line_addr = '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            ret_data  <= '0;
            wr_rdy    <= 1'b0;
            busy      <= 1'b0;
            beat      <= 0;
        end else begin
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            wr_rdy    <= ($random(seed) & 3) == 0;
            if (wr_req) begin
                for (int i = 0; i < WORDS_PER_LINE; i++)
                    mem[wr_addr + ADDR_W'(4 * i)] = wr_data[i*WORD_W +: WORD_W];
            end
            if (busy) begin
                if (($random(seed) & 3) != 0) begin // else a gap in the burst
                    ret_valid <= 1'b1;
                    ret_data  <= load_word(line_addr + ADDR_W'(4 * beat));
                    ret_last  <= (beat == WORDS_PER_LINE - 1);
                    beat      <= beat + 1;
                    if (beat == WORDS_PER_LINE - 1)
                        busy <= 1'b0;
                end
            end else if (rd_req && rd_rdy) begin
                busy      <= 1'b1;
                beat      <= 0;
                line_addr <= rd_addr;
            end else if (rd_req) begin
                rd_rdy <= ($random(seed) & 3) == 0;
            end
        end
    end

endmodule

// ==== verif/cache_tb.sv ====
// cache testbench: table-driven cpu requests against the cache and a random-latency memory
`timescale 1ns/100ps

module cache_tb
    import cache_pkg::*;
();

    localparam int                CLK_HALF        = 5;
    localparam int                RESET_CYCLES    = 10;
    localparam int                NUM_ENTRY       = 26;
    localparam int                WATCHDOG_CYCLES = NUM_ENTRY * 200;
    localparam int                LINE_W          = 16 * 8;
    localparam logic [WORD_W-1:0] MEM_XOR         = 32'h3c00_0000;

    // expected data_ok level in the lookup cycle of a read
    localparam logic [1:0] RSP_MISS = 2'd0;
    localparam logic [1:0] RSP_HIT  = 2'd1;
    localparam logic [1:0] RSP_ANY  = 2'd2; // depends on the random victim

    typedef struct packed {
        logic              wr;
        logic [1:0]        rsp;
        logic [ADDR_W-1:0] addr;
        logic [STRB_W-1:0] strb;
        logic [WORD_W-1:0] wdata;
        logic [WORD_W-1:0] exp_word;
    } stim_entry_t;

    stim_entry_t stim [NUM_ENTRY];

    logic               clk = 1'b0;
    logic               reset;
    logic               valid;
    logic               write;
    logic [ADDR_W-1:0]  addr;
    logic [STRB_W-1:0]  wstrb;
    logic [WORD_W-1:0]  wdata;
    logic               addr_ok;
    logic               data_ok;
    logic [WORD_W-1:0]  rdata;
    logic               rd_req;
    logic [ADDR_W-1:0]  rd_addr;
    logic               rd_rdy;
    logic               ret_valid;
    logic               ret_last;
    logic [WORD_W-1:0]  ret_data;
    logic               wr_req;
    logic [ADDR_W-1:0]  wr_addr;
    logic [LINE_W-1:0]  wr_data;
    logic               wr_rdy;
    int                 wb_count = 0;

    cache_top i_dut (.*);

    cache_mem_model #(.INIT_XOR(MEM_XOR)) i_mem (.*);

    always #CLK_HALF clk = ~clk;

    always @(posedge clk)
        if (!reset && wr_req)
            wb_count <= wb_count + 1; // write-back pulses

    task automatic check_word(string what, logic [WORD_W-1:0] actual,
                              logic [WORD_W-1:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_state_flag(string what, logic actual, logic expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s, got %b, expected %b", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_idle_outputs(string when);
        check_state_flag({"addr_ok ", when}, addr_ok, 1'b0);
        check_state_flag({"data_ok ", when}, data_ok, 1'b0);
        check_state_flag({"rd_req ", when}, rd_req, 1'b0);
        check_state_flag({"wr_req ", when}, wr_req, 1'b0);
    endtask

    // memory word at a = a ^ 3c00_0000 unless written
    task automatic load_table();
        stim[0]  = '{1'b0, RSP_MISS, 32'h0000_1040, 4'b0000, 32'h0, 32'h3c00_1040};
        stim[1]  = '{1'b0, RSP_HIT,  32'h0000_1040, 4'b0000, 32'h0, 32'h3c00_1040};
        stim[2]  = '{1'b1, RSP_HIT,  32'h0000_1044, 4'b0011, 32'hdead_beef, 32'h0};
        stim[3]  = '{1'b0, RSP_HIT,  32'h0000_1044, 4'b0000, 32'h0, 32'h3c00_beef};
        stim[4]  = '{1'b1, RSP_HIT,  32'h0000_2048, 4'b1100, 32'h1234_5678, 32'h0};
        stim[5]  = '{1'b0, RSP_HIT,  32'h0000_2048, 4'b0000, 32'h0, 32'h1234_2048};
        stim[6]  = '{1'b0, RSP_MISS, 32'h0000_3040, 4'b0000, 32'h0, 32'h3c00_3040};
        stim[7]  = '{1'b0, RSP_ANY,  32'h0000_1044, 4'b0000, 32'h0, 32'h3c00_beef};
        stim[8]  = '{1'b0, RSP_ANY,  32'h0000_2048, 4'b0000, 32'h0, 32'h1234_2048};
        stim[9]  = '{1'b0, RSP_ANY,  32'h0000_1040, 4'b0000, 32'h0, 32'h3c00_1040};
        stim[10] = '{1'b1, RSP_HIT,  32'h0000_4044, 4'b0001, 32'h0000_0099, 32'h0};
        stim[11] = '{1'b0, RSP_HIT,  32'h0000_4044, 4'b0000, 32'h0, 32'h3c00_4099};
        stim[12] = '{1'b1, RSP_HIT,  32'h0000_0100, 4'b1111, 32'h0bad_f00d, 32'h0};
        stim[13] = '{1'b0, RSP_HIT,  32'h0000_0100, 4'b0000, 32'h0, 32'h0bad_f00d};
        stim[14] = '{1'b0, RSP_HIT,  32'h0000_010c, 4'b0000, 32'h0, 32'h3c00_010c};
        stim[15] = '{1'b1, RSP_HIT,  32'h0000_0108, 4'b0100, 32'h00ab_0000, 32'h0};
        stim[16] = '{1'b0, RSP_HIT,  32'h0000_0108, 4'b0000, 32'h0, 32'h3cab_0108};
        stim[17] = '{1'b0, RSP_MISS, 32'h0000_0ff0, 4'b0000, 32'h0, 32'h3c00_0ff0};
        stim[18] = '{1'b1, RSP_HIT,  32'h0000_0ffc, 4'b1000, 32'h7700_0000, 32'h0};
        stim[19] = '{1'b0, RSP_MISS, 32'h0000_1ff4, 4'b0000, 32'h0, 32'h3c00_1ff4};
        stim[20] = '{1'b0, RSP_MISS, 32'h0000_2ff8, 4'b0000, 32'h0, 32'h3c00_2ff8};
        stim[21] = '{1'b0, RSP_ANY,  32'h0000_0ffc, 4'b0000, 32'h0, 32'h7700_0ffc};
        stim[22] = '{1'b0, RSP_HIT,  32'h0000_0ff0, 4'b0000, 32'h0, 32'h3c00_0ff0};
        stim[23] = '{1'b0, RSP_HIT,  32'h0000_0104, 4'b0000, 32'h0, 32'h3c00_0104};
        stim[24] = '{1'b0, RSP_ANY,  32'h0000_2048, 4'b0000, 32'h0, 32'h1234_2048};
        stim[25] = '{1'b0, RSP_ANY,  32'h0000_1044, 4'b0000, 32'h0, 32'h3c00_beef};
    endtask

    task automatic reset_dut();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1)
                reset <= 1'b0;
            @(negedge clk);
            check_idle_outputs("during reset");
        end
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs("after reset");
        end
    endtask

    task automatic apply_entry(int n);
        stim_entry_t e;
        string       tag;
        e   = stim[n];
        tag = $sformatf("entry %0d %s %h", n, e.wr ? "write" : "read", e.addr);
        @(posedge clk);
        valid <= 1'b1;
        write <= e.wr;
        addr  <= e.addr;
        wstrb <= e.strb;
        wdata <= e.wdata;
        @(negedge clk);
        while (!addr_ok)
            @(negedge clk);
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk); // lookup cycle
        if (e.wr || e.rsp == RSP_HIT)
            check_state_flag({tag, ": data_ok one cycle after addr_ok"}, data_ok, 1'b1);
        else if (e.rsp == RSP_MISS)
            check_state_flag({tag, ": data_ok in lookup of a miss"}, data_ok, 1'b0);
        while (!data_ok)
            @(negedge clk);
        if (!e.wr)
            check_word({tag, ": rdata"}, rdata, e.exp_word);
    endtask

    initial begin
        reset = 1'b1;
        valid = 1'b0;
        write = 1'b0;
        addr  = '0;
        wstrb = '0;
        wdata = '0;
        load_table();
        reset_dut();
        for (int n = 0; n < NUM_ENTRY; n++)
            apply_entry(n);
        check_state_flag("dirty victim written back", wb_count != 0, 1'b1);
        $display("TEST OK");
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: the cache did not finish the request table in %0d cycles",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "run stopped by the watchdog");
    end

endmodule

// ==== sources.f ====
design/cache_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_victim_select.sv
design/cache_ctrl.sv
design/cache_top.sv
verif/cache_mem_model.sv
verif/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the cache testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cache_tb -f sources.f -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
